//--- verilog/datapath_pkg.sv
// RV32I subset encodings only; HALT is the all-ones word and funct fields outside the subset decode as add
`default_nettype none

package datapath_pkg;

    parameter int WORD_W = 32;
    parameter int REG_W  = 5;
    parameter int NREGS  = 32;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_W-1:0]  reg_sel_t;

    // base opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        HALT   = 7'b1111111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_sel_t   rs2;
        reg_sel_t   rs1;
        logic [2:0] funct3;
        reg_sel_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_sel_t    rs1;
        logic [2:0]  funct3;
        reg_sel_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // S and B immediates come out of the r view (funct7 and rd)
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    typedef enum logic [1:0] {
        FU_NONE,
        FU_ALU,
        FU_LS,
        FU_BR
    } fu_sel_t;

    localparam word_t HALT_WORD = '1;

endpackage

`default_nettype wire

//--- verilog/fetch_stage.sv
// memory must hold a request open until ihit; a redirect waits for an open request to finish
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
    parameter datapath_pkg::word_t RESET_PC = '0
) (
    input  logic                   CLK,
    input  logic                   nrst,
    input  logic                   ihit,
    input  datapath_pkg::word_t    imemload,
    input  logic                   freeze,
    input  logic                   branch_miss,
    input  datapath_pkg::word_t    correct_pc,
    input  logic                   halt,
    output logic                   imemREN,
    output datapath_pkg::word_t    imemaddr,
    output datapath_pkg::instr_u   instr,
    output datapath_pkg::word_t    pc,
    output logic                   fetch_valid
);
    import datapath_pkg::*;

    word_t pc_q;
    word_t target_q;
    logic  run_q;
    logic  squash_q;

    assign imemREN  = run_q && !halt;
    assign imemaddr = pc_q;
    assign pc       = pc_q;
    assign instr    = imemload;

    // a word answered for a squashed address never reaches the latch
    assign fetch_valid = imemREN && ihit && !squash_q && !branch_miss;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc_q     <= RESET_PC;
            target_q <= RESET_PC;
            run_q    <= 1'b0;
            squash_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (branch_miss) begin
                if (imemREN && !ihit) begin
                    // old request still open, finish it first
                    squash_q <= 1'b1;
                    target_q <= correct_pc;
                end else begin
                    pc_q     <= correct_pc;
                    squash_q <= 1'b0;
                end
            end else if (squash_q && ihit) begin
                pc_q     <= target_q;
                squash_q <= 1'b0;
            end else if (fetch_valid && !freeze) begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/regfile.sv
// x0 reads zero and ignores writes; a same-cycle write is returned on both read ports
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                   CLK,
    input  logic                   nrst,
    input  logic                   wen,
    input  datapath_pkg::reg_sel_t wsel,
    input  datapath_pkg::word_t    wdat,
    input  datapath_pkg::reg_sel_t rsel1,
    input  datapath_pkg::reg_sel_t rsel2,
    output datapath_pkg::word_t    rdat1,
    output datapath_pkg::word_t    rdat2
);
    import datapath_pkg::*;

    word_t regs [NREGS];
    logic  wr_ok;

    assign wr_ok = wen && (wsel != '0);

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            regs <= '{default: '0};
        end else if (wr_ok) begin
            regs[wsel] <= wdat;
        end
    end

    // write-first bypass
    always_comb begin
        rdat1 = (wr_ok && wsel == rsel1) ? wdat : regs[rsel1];
        rdat2 = (wr_ok && wsel == rsel2) ? wdat : regs[rsel2];
    end

endmodule

`default_nettype wire

//--- verilog/scoreboard.sv
// one issue slot; unknown opcodes issue as no-ops with no register effect
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
    input  logic                   CLK,
    input  logic                   nrst,
    input  datapath_pkg::instr_u   instr,
    input  datapath_pkg::word_t    pc,
    input  logic                   fetch_valid,
    input  logic                   ex_busy,
    input  logic                   branch_miss,
    input  logic                   wb_reg_en,
    input  datapath_pkg::reg_sel_t wb_reg_sel,
    input  datapath_pkg::word_t    wb_wdat,
    output logic                   freeze,
    output logic                   issue_valid,
    output datapath_pkg::fu_sel_t  fu_sel,
    output datapath_pkg::alu_op_t  alu_op,
    output datapath_pkg::word_t    rdat1,
    output datapath_pkg::word_t    rdat2,
    output datapath_pkg::word_t    imm,
    output datapath_pkg::word_t    issue_pc,
    output datapath_pkg::reg_sel_t rd,
    output logic                   is_store,
    output logic                   branch_ne,
    output logic                   is_jal,
    output logic                   is_halt
);
    import datapath_pkg::*;

    opcode_t          op;
    fu_sel_t          fu_d;
    alu_op_t          alu_d;
    word_t            imm_d;
    word_t            rf_rdat1;
    word_t            rf_rdat2;
    reg_sel_t         rd_d;
    logic             use_rs1;
    logic             use_rs2;
    logic             writes;
    logic             hazard;
    logic             fire;
    logic [NREGS-1:0] busy_q;
    logic [NREGS-1:0] busy_now;
    logic [NREGS-1:0] busy_set;

    regfile u_regfile (
        .CLK(CLK), .nrst(nrst),
        .wen(wb_reg_en), .wsel(wb_reg_sel), .wdat(wb_wdat),
        .rsel1(instr.r.rs1), .rsel2(instr.r.rs2),
        .rdat1(rf_rdat1), .rdat2(rf_rdat2)
    );

    assign op = opcode_t'(instr.r.opcode);

    always_comb begin
        fu_d    = FU_NONE;
        alu_d   = ALU_ADD;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        writes  = 1'b0;
        imm_d   = {{20{instr.i.imm12[11]}}, instr.i.imm12};
        case (op)
            OP, OP_IMM: begin
                fu_d    = FU_ALU;
                use_rs1 = 1'b1;
                use_rs2 = (op == OP);
                writes  = 1'b1;
                case (instr.r.funct3)
                    3'b111:  alu_d = ALU_AND;
                    3'b110:  alu_d = ALU_OR;
                    3'b100:  alu_d = ALU_XOR;
                    3'b010:  alu_d = ALU_SLT;
                    default: alu_d = (op == OP && instr.r.funct7[5]) ? ALU_SUB : ALU_ADD;
                endcase
            end
            LOAD: begin
                fu_d    = FU_LS;
                use_rs1 = 1'b1;
                writes  = 1'b1;
            end
            STORE: begin
                fu_d    = FU_LS;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm_d   = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rd};
            end
            BRANCH: begin
                fu_d    = FU_BR;
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                imm_d   = {{19{instr.r.funct7[6]}}, instr.r.funct7[6], instr.r.rd[0],
                           instr.r.funct7[5:0], instr.r.rd[4:1], 1'b0};
            end
            JAL: begin
                fu_d   = FU_BR;
                writes = 1'b1;
                imm_d  = {{11{instr.i.imm12[11]}}, instr.i.imm12[11], instr.i.rs1,
                          instr.i.funct3, instr.i.imm12[0], instr.i.imm12[10:1], 1'b0};
            end
            default: begin
            end
        endcase
        // x0 as destination is no write at all
        writes = writes && (instr.r.rd != '0);
    end

    assign rd_d = writes ? instr.r.rd : '0;

    // a register released by writeback this cycle counts as free
    assign busy_now = busy_q & ~({{(NREGS-1){1'b0}}, wb_reg_en} << wb_reg_sel);
    assign hazard   = (use_rs1 && busy_now[instr.r.rs1]) ||
                      (use_rs2 && busy_now[instr.r.rs2]) ||
                      (writes && busy_now[rd_d]);
    assign freeze   = fetch_valid && (hazard || ex_busy);
    assign fire     = fetch_valid && !hazard && !ex_busy && !branch_miss;
    assign busy_set = {{(NREGS-1){1'b0}}, fire && writes} << rd_d;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy_q      <= '0;
            issue_valid <= 1'b0;
        end else begin
            busy_q <= busy_now | busy_set;
            if (!ex_busy || branch_miss) begin
                issue_valid <= fire;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fire) begin
            fu_sel    <= fu_d;
            alu_op    <= alu_d;
            rdat1     <= rf_rdat1;
            rdat2     <= (op == OP_IMM) ? imm_d : rf_rdat2;
            imm       <= imm_d;
            issue_pc  <= pc;
            rd        <= rd_d;
            is_store  <= (op == STORE);
            branch_ne <= instr.r.funct3[0];
            is_jal    <= (op == JAL);
            is_halt   <= (op == HALT) && (instr == HALT_WORD);
        end
    end

endmodule

`default_nettype wire

//--- verilog/execute.sv
// word loads and stores only; the issue register must stay stable while ex_busy is high
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  logic                   CLK,
    input  logic                   nrst,
    input  logic                   issue_valid,
    input  datapath_pkg::fu_sel_t  fu_sel,
    input  datapath_pkg::alu_op_t  alu_op,
    input  datapath_pkg::word_t    rdat1,
    input  datapath_pkg::word_t    rdat2,
    input  datapath_pkg::word_t    imm,
    input  datapath_pkg::word_t    issue_pc,
    input  datapath_pkg::reg_sel_t rd,
    input  logic                   is_store,
    input  logic                   branch_ne,
    input  logic                   is_jal,
    input  logic                   is_halt,
    input  logic                   dhit,
    input  datapath_pkg::word_t    dmemload,
    output logic                   dmemREN,
    output logic                   dmemWEN,
    output datapath_pkg::word_t    dmemaddr,
    output datapath_pkg::word_t    dmemstore,
    output logic                   ex_busy,
    output logic                   branch_resolved,
    output logic                   branch_miss,
    output datapath_pkg::word_t    correct_pc,
    output logic                   halt,
    output logic                   done,
    output datapath_pkg::word_t    wdat,
    output datapath_pkg::reg_sel_t reg_sel
);
    import datapath_pkg::*;

    word_t alu_out;
    logic  ls_req;
    logic  taken;
    logic  halt_q;

    always_comb begin
        case (alu_op)
            ALU_SUB: alu_out = rdat1 - rdat2;
            ALU_AND: alu_out = rdat1 & rdat2;
            ALU_OR:  alu_out = rdat1 | rdat2;
            ALU_XOR: alu_out = rdat1 ^ rdat2;
            ALU_SLT: alu_out = {{(WORD_W-1){1'b0}}, $signed(rdat1) < $signed(rdat2)};
            default: alu_out = rdat1 + rdat2;
        endcase
    end

    // request level follows the issue register until dhit
    assign ls_req    = issue_valid && (fu_sel == FU_LS);
    assign dmemREN   = ls_req && !is_store;
    assign dmemWEN   = ls_req && is_store;
    assign dmemaddr  = rdat1 + imm;
    assign dmemstore = rdat2;

    assign halt    = halt_q || (issue_valid && is_halt);
    assign ex_busy = (ls_req && !dhit) || halt;

    // static not-taken, so every taken branch is a miss
    assign branch_resolved = issue_valid && (fu_sel == FU_BR);
    assign taken           = is_jal || ((rdat1 == rdat2) != branch_ne);
    assign branch_miss     = branch_resolved && taken;
    assign correct_pc      = issue_pc + imm;

    always_comb begin
        done = 1'b0;
        wdat = alu_out;
        if (issue_valid) begin
            case (fu_sel)
                FU_ALU: done = 1'b1;
                FU_LS: begin
                    done = dhit && !is_store;
                    wdat = dmemload;
                end
                FU_BR: begin
                    done = is_jal;
                    wdat = issue_pc + 32'd4;
                end
                default: done = 1'b0;
            endcase
        end
    end

    assign reg_sel = rd;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            halt_q <= 1'b0;
        end else if (issue_valid && is_halt) begin
            halt_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/writeback.sv
// one write per cycle; results aimed at x0 never raise reg_en
`timescale 1ns/1ps
`default_nettype none

module writeback (
    input  logic                   CLK,
    input  logic                   nrst,
    input  logic                   done,
    input  datapath_pkg::word_t    wdat,
    input  datapath_pkg::reg_sel_t reg_sel,
    output logic                   reg_en,
    output datapath_pkg::reg_sel_t wb_reg_sel,
    output datapath_pkg::word_t    wb_wdat
);
    import datapath_pkg::*;

    logic     done_q;
    reg_sel_t sel_q;
    word_t    wdat_q;

    // execute to writeback latch
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= done;
        end
    end

    always_ff @(posedge CLK) begin
        sel_q  <= reg_sel;
        wdat_q <= wdat;
    end

    // same strobe feeds the register file and the busy release
    assign reg_en     = done_q && (sel_q != '0);
    assign wb_reg_sel = sel_q;
    assign wb_wdat    = wdat_q;

endmodule

`default_nettype wire

//--- verilog/sc_datapath.sv
// RESET_PC must be word aligned; both memories answer a held request with a one-cycle hit
`timescale 1ns/1ps
`default_nettype none

module sc_datapath #(
    parameter datapath_pkg::word_t RESET_PC = '0
) (
    input  logic                CLK,
    input  logic                nrst,
    output logic                imemREN,
    output datapath_pkg::word_t imemaddr,
    input  logic                ihit,
    input  datapath_pkg::word_t imemload,
    output logic                dmemREN,
    output logic                dmemWEN,
    output datapath_pkg::word_t dmemaddr,
    output datapath_pkg::word_t dmemstore,
    input  logic                dhit,
    input  datapath_pkg::word_t dmemload,
    output logic                halt
);
    import datapath_pkg::*;

    instr_u   f_instr, fl_instr;
    word_t    f_pc, fl_pc;
    logic     fetch_valid, fl_valid, freeze;
    logic     issue_valid, is_store, branch_ne, is_jal, is_halt;
    fu_sel_t  fu_sel;
    alu_op_t  alu_op;
    word_t    rdat1, rdat2, imm, issue_pc, correct_pc;
    reg_sel_t rd, ex_reg_sel, wb_reg_sel;
    logic     ex_busy, branch_miss, ex_done, wb_reg_en;
    word_t    ex_wdat, wb_wdat;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .CLK(CLK), .nrst(nrst), .ihit(ihit), .imemload(imemload),
        .freeze(freeze), .branch_miss(branch_miss), .correct_pc(correct_pc), .halt(halt),
        .imemREN(imemREN), .imemaddr(imemaddr),
        .instr(f_instr), .pc(f_pc), .fetch_valid(fetch_valid)
    );

    // fetch latch, held by freeze and emptied by a miss
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            fl_valid <= 1'b0;
        end else if (branch_miss) begin
            fl_valid <= 1'b0;
        end else if (!freeze) begin
            fl_valid <= fetch_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!freeze) begin
            fl_instr <= f_instr;
            fl_pc    <= f_pc;
        end
    end

    scoreboard u_scoreboard (
        .CLK(CLK), .nrst(nrst), .instr(fl_instr), .pc(fl_pc), .fetch_valid(fl_valid),
        .ex_busy(ex_busy), .branch_miss(branch_miss),
        .wb_reg_en(wb_reg_en), .wb_reg_sel(wb_reg_sel), .wb_wdat(wb_wdat),
        .freeze(freeze), .issue_valid(issue_valid), .fu_sel(fu_sel), .alu_op(alu_op),
        .rdat1(rdat1), .rdat2(rdat2), .imm(imm), .issue_pc(issue_pc), .rd(rd),
        .is_store(is_store), .branch_ne(branch_ne), .is_jal(is_jal), .is_halt(is_halt)
    );

    // resolution strobe has no consumer with static not-taken prediction
    execute u_execute (
        .CLK(CLK), .nrst(nrst), .issue_valid(issue_valid), .fu_sel(fu_sel), .alu_op(alu_op),
        .rdat1(rdat1), .rdat2(rdat2), .imm(imm), .issue_pc(issue_pc), .rd(rd),
        .is_store(is_store), .branch_ne(branch_ne), .is_jal(is_jal), .is_halt(is_halt),
        .dhit(dhit), .dmemload(dmemload), .dmemREN(dmemREN), .dmemWEN(dmemWEN),
        .dmemaddr(dmemaddr), .dmemstore(dmemstore), .ex_busy(ex_busy),
        .branch_resolved(), .branch_miss(branch_miss), .correct_pc(correct_pc),
        .halt(halt), .done(ex_done), .wdat(ex_wdat), .reg_sel(ex_reg_sel)
    );

    writeback u_writeback (
        .CLK(CLK), .nrst(nrst), .done(ex_done), .wdat(ex_wdat), .reg_sel(ex_reg_sel),
        .reg_en(wb_reg_en), .wb_reg_sel(wb_reg_sel), .wb_wdat(wb_wdat)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// free-running clock from time zero, low first; PERIOD in ns and even
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic CLK
);

    initial begin
        CLK = 1'b0;
    end

    always begin
        #(PERIOD / 2);
        CLK = ~CLK;
    end

endmodule

`default_nettype wire

//--- testbench/tb_sc_datapath.sv
// word memories only (128 instr, 64 data words); hit delay of 0 to 3 idle cycles per request
`timescale 1ns/1ps
`default_nettype none

module tb_sc_datapath;
    import datapath_pkg::*;

    localparam word_t      BOOT_PC      = 32'h80;
    localparam int         HALT_TIMEOUT = 2000;
    localparam int         MAX_STORES   = 32;
    localparam logic [6:0] OPC_OP       = 7'h33;
    localparam logic [6:0] OPC_IMM      = 7'h13;
    localparam logic [6:0] OPC_LOAD     = 7'h03;
    localparam logic [6:0] OPC_STORE    = 7'h23;
    localparam logic [6:0] OPC_BRANCH   = 7'h63;
    localparam logic [6:0] OPC_JAL      = 7'h6f;

    logic        CLK;
    logic        nrst = 1'b1;
    logic        imemREN;
    word_t       imemaddr;
    logic        ihit = 1'b0;
    word_t       imemload = '0;
    logic        dmemREN;
    logic        dmemWEN;
    word_t       dmemaddr;
    word_t       dmemstore;
    logic        dhit = 1'b0;
    word_t       dmemload = '0;
    logic        halt;

    word_t       imem [128];
    word_t       dmem [64];
    word_t       ref_mem [64];
    word_t       exp_addr [MAX_STORES];
    word_t       exp_data [MAX_STORES];
    int          exp_count = 0;
    int          stores_seen = 0;
    int          errors = 0;
    int          prog_len = 0;
    int          cycles = 0;
    logic [31:0] rng_state = 32'ha8717e9d;
    logic [1:0]  icount = '0;
    logic [1:0]  dcount = '0;
    logic        ibusy = 1'b0;
    logic        dbusy = 1'b0;
    word_t       held_addr = '0;
    word_t       held_data = '0;
    logic        req_seen = 1'b0;
    logic        halt_seen = 1'b0;

    tb_clock #(.PERIOD(100)) u_clock (.CLK(CLK));

    sc_datapath #(.RESET_PC(BOOT_PC)) uut (
        .CLK(CLK), .nrst(nrst),
        .imemREN(imemREN), .imemaddr(imemaddr), .ihit(ihit), .imemload(imemload),
        .dmemREN(dmemREN), .dmemWEN(dmemWEN), .dmemaddr(dmemaddr), .dmemstore(dmemstore),
        .dhit(dhit), .dmemload(dmemload), .halt(halt)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t dmem_fill(input word_t addr);
        return (addr * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    function automatic word_t enc_r(input int f7, input int rs2, input int rs1,
                                    input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    function automatic word_t enc_i(input int imm, input int rs1, input int f3,
                                    input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic word_t enc_s(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input int imm, input int rs2, input int rs1, input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    task automatic place_instr(input word_t w);
        imem[(BOOT_PC >> 2) + prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        place_instr(enc_i(5, 0, 0, 1, OPC_IMM));
        place_instr(enc_i(-3, 0, 0, 2, OPC_IMM));
        // back-to-back dependent ALU chain
        place_instr(enc_r(0, 2, 1, 0, 3));
        place_instr(enc_r(32, 3, 1, 0, 4));
        place_instr(enc_r(0, 2, 4, 4, 5));
        place_instr(enc_r(0, 1, 4, 6, 6));
        place_instr(enc_r(0, 2, 6, 7, 7));
        place_instr(enc_r(0, 7, 2, 2, 8));
        place_instr(enc_i(64, 0, 0, 10, OPC_IMM));
        place_instr(enc_s(0, 3, 10));
        place_instr(enc_s(4, 4, 10));
        place_instr(enc_s(8, 6, 10));
        place_instr(enc_s(12, 7, 10));
        place_instr(enc_s(16, 8, 10));
        place_instr(enc_s(48, 5, 10));
        // load then dependent use, twice
        place_instr(enc_i(32, 10, 2, 11, OPC_LOAD));
        place_instr(enc_r(0, 1, 11, 0, 12));
        place_instr(enc_s(20, 12, 10));
        place_instr(enc_i(20, 10, 2, 13, OPC_LOAD));
        place_instr(enc_r(32, 11, 13, 0, 14));
        place_instr(enc_s(24, 14, 10));
        // beq not taken, beq taken, bne not taken, bne taken
        place_instr(enc_b(8, 2, 1, 0));
        place_instr(enc_s(28, 1, 10));
        place_instr(enc_b(8, 3, 3, 0));
        place_instr(enc_s(28, 2, 10));
        place_instr(enc_b(8, 1, 1, 1));
        place_instr(enc_i(7, 0, 0, 15, OPC_IMM));
        place_instr(enc_b(8, 2, 1, 1));
        place_instr(enc_s(32, 15, 10));
        // jal over two wrong-path stores, link stored afterwards
        place_instr(enc_j(12, 16));
        place_instr(enc_s(36, 0, 10));
        place_instr(enc_s(36, 0, 10));
        place_instr(enc_s(40, 16, 10));
        place_instr(enc_s(44, 15, 10));
        place_instr(HALT_WORD);
    endtask

    // in-order ISA model, fills the expected store sequence and ref_mem
    task automatic run_reference();
        word_t regs [32];
        word_t pc;
        word_t w;
        word_t a;
        word_t b;
        word_t res;
        word_t ea;
        word_t next_pc;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        logic  wr;
        logic  stop;
        int    steps;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        pc    = BOOT_PC;
        stop  = 1'b0;
        steps = 0;
        while (!stop && steps < 1000) begin
            w       = imem[pc[8:2]];
            a       = regs[w[19:15]];
            b       = regs[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            next_pc = pc + 32'd4;
            wr      = 1'b0;
            res     = '0;
            if (w == HALT_WORD) begin
                stop = 1'b1;
            end else begin
                case (w[6:0])
                    OPC_OP: begin
                        wr = 1'b1;
                        case (w[14:12])
                            3'd2:    res = {31'b0, $signed(a) < $signed(b)};
                            3'd4:    res = a ^ b;
                            3'd6:    res = a | b;
                            3'd7:    res = a & b;
                            default: res = w[30] ? a - b : a + b;
                        endcase
                    end
                    OPC_IMM: begin
                        wr  = 1'b1;
                        res = a + imm_i;
                    end
                    OPC_LOAD: begin
                        wr  = 1'b1;
                        ea  = a + imm_i;
                        res = ref_mem[ea[7:2]];
                    end
                    OPC_STORE: begin
                        ea = a + imm_s;
                        ref_mem[ea[7:2]] = b;
                        if (exp_count < MAX_STORES) begin
                            exp_addr[exp_count] = ea;
                            exp_data[exp_count] = b;
                            exp_count++;
                        end
                    end
                    OPC_BRANCH: begin
                        if ((a == b) != w[12]) begin
                            next_pc = pc + imm_b;
                        end
                    end
                    OPC_JAL: begin
                        wr      = 1'b1;
                        res     = pc + 32'd4;
                        next_pc = pc + imm_j;
                    end
                    default: begin
                    end
                endcase
            end
            if (wr && w[11:7] != 5'd0) begin
                regs[w[11:7]] = res;
            end
            pc = next_pc;
            steps++;
        end
    endtask

    task automatic check_store(input word_t addr, input word_t data);
        assert (stores_seen < exp_count) else begin
            $display("store of %h to %h is not in the expected sequence", data, addr);
            errors++;
        end
        if (stores_seen < exp_count) begin
            assert (addr == exp_addr[stores_seen]) else begin
                $display("Fail dmemaddr: got %h expected %h", addr, exp_addr[stores_seen]);
                errors++;
            end
            assert (data == exp_data[stores_seen]) else begin
                $display("Fail dmemstore: got %h expected %h", data, exp_data[stores_seen]);
                errors++;
            end
        end
        stores_seen++;
    endtask

    // both memory models; one block so the random draws keep a fixed order
    always @(posedge CLK) begin
        if (ihit) begin
            ihit <= 1'b0;
        end else if (nrst && imemREN) begin
            if (!ibusy) begin
                rng_state = next_random(rng_state);
                icount    = rng_state[17:16];
                ibusy     = 1'b1;
            end
            if (icount == 2'd0) begin
                ihit     <= 1'b1;
                imemload <= imem[imemaddr[8:2]];
                ibusy     = 1'b0;
            end else begin
                icount = icount - 2'd1;
            end
        end else begin
            ibusy = 1'b0;
        end

        if (dhit) begin
            dhit <= 1'b0;
        end else if (nrst && (dmemREN || dmemWEN)) begin
            if (!dbusy) begin
                rng_state = next_random(rng_state);
                dcount    = rng_state[17:16];
                dbusy     = 1'b1;
                held_addr = dmemaddr;
                held_data = dmemstore;
            end else begin
                assert (dmemaddr == held_addr) else begin
                    $display("Fail dmemaddr: moved from %h to %h before dhit",
                             held_addr, dmemaddr);
                    errors++;
                end
                assert (dmemstore == held_data) else begin
                    $display("Fail dmemstore: moved from %h to %h before dhit",
                             held_data, dmemstore);
                    errors++;
                end
            end
            if (dcount == 2'd0) begin
                dhit <= 1'b1;
                dbusy = 1'b0;
                if (dmemWEN) begin
                    check_store(dmemaddr, dmemstore);
                    dmem[dmemaddr[7:2]] = dmemstore;
                end else begin
                    dmemload <= dmem[dmemaddr[7:2]];
                end
            end else begin
                dcount = dcount - 2'd1;
            end
        end else begin
            assert (!dbusy) else begin
                $display("data request dropped before dhit");
                errors++;
            end
            dbusy = 1'b0;
        end
    end

    // reset values, first fetch address and halt behavior
    always @(posedge CLK) begin
        if (!nrst) begin
            assert (!imemREN && !dmemREN && !dmemWEN && !halt) else begin
                $display("a memory request or halt is active during reset");
                errors++;
            end
        end else begin
            if (imemREN && !req_seen) begin
                req_seen = 1'b1;
                assert (imemaddr == BOOT_PC) else begin
                    $display("Fail imemaddr: got %h expected %h", imemaddr, BOOT_PC);
                    errors++;
                end
            end
            if (halt_seen) begin
                assert (halt) else begin
                    $display("halt went low after it was raised");
                    errors++;
                end
            end
            if (halt) begin
                halt_seen = 1'b1;
                assert (!imemREN && !dmemREN && !dmemWEN) else begin
                    $display("a memory request was made while halted");
                    errors++;
                end
            end
        end
    end

    initial begin
        // reset edge at time zero
        nrst <= 1'b0;
        for (int k = 0; k < 128; k++) begin
            imem[k] = '0;
        end
        for (int k = 0; k < 64; k++) begin
            dmem[k]    = dmem_fill(k * 4);
            ref_mem[k] = dmem[k];
        end
        build_program();
        run_reference();

        repeat (3) @(posedge CLK);
        nrst <= 1'b1;

        cycles = 0;
        while (!halt && cycles < HALT_TIMEOUT) begin
            @(posedge CLK);
            cycles++;
        end
        if (!halt) begin
            $display("timeout, halt did not rise within %0d cycles", HALT_TIMEOUT);
            errors++;
        end
        // short window for the halt monitor
        repeat (5) @(posedge CLK);

        for (int k = 0; k < 64; k++) begin
            assert (dmem[k] == ref_mem[k]) else begin
                $display("Fail dmem[%h]: got %h expected %h", k * 4, dmem[k], ref_mem[k]);
                errors++;
            end
        end
        assert (stores_seen == exp_count) else begin
            $display("saw %0d stores but the program makes %0d", stores_seen, exp_count);
            errors++;
        end

        $display("errors %0d, stores %0d of %0d, cycles to halt %0d",
                 errors, stores_seen, exp_count, cycles);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
verilog/datapath_pkg.sv
verilog/fetch_stage.sv
verilog/regfile.sv
verilog/scoreboard.sv
verilog/execute.sv
verilog/writeback.sv
verilog/sc_datapath.sv
testbench/tb_clock.sv
testbench/tb_sc_datapath.sv
